// File: sdio_dev_top.f
+incdir+common
common/sdio_proto_pkg.sv
common/sdio_func_pkg.sv
sdio_cmd/crc7.sv
sdio_cmd/sdio_cmd.sv
verilog/sdio_io_dispatch.sv
verilog/sdio_func_regs.sv
verilog/sdio_resp_merge.sv
verilog/sdio_dev_top.sv
verification/sdio_dev_chk.sv
verification/sdio_dev_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the SDIO device testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module sdio_dev_tb -f sdio_dev_top.f -Mdir obj_dir -o sdio_dev_sim
if [ $? -ne 0 ]; then
    echo "Verilator build did not succeed"
    exit 1
fi

OUT=$(./obj_dir/sdio_dev_sim 2>&1)
STATUS=$?
printf '%s\n' "$OUT"
if [ $STATUS -ne 0 ]; then
    echo "Simulation exited with status $STATUS"
    exit 1
fi

if printf '%s\n' "$OUT" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: verification/sdio_dev_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdio_params.svh"

module sdio_dev_tb;

    localparam logic [5:0] CMD52     = 6'd52;
    localparam int         FW        = $clog2(`SDIO_NUM_FUNC);
    localparam int         AW        = $clog2(`SDIO_REG_DEPTH);
    localparam int         IDLE_CYC  = 4;
    localparam int         RESP_WAIT = 40;   // Cycles allowed until the start bit
    localparam int         NUM_CMDS  = 18;
    localparam int         WATCHDOG_NS = (NUM_CMDS * (IDLE_CYC + 48 + RESP_WAIT + 48) + 100) * 4;

    logic       clk_sdio;
    logic       arst_n;
    logic       host_oe;
    logic       host_bit;
    wire        cmd_sdio;
    logic [7:0] shadow [`SDIO_NUM_FUNC][`SDIO_REG_DEPTH];  // Bank model
    int         err_cnt;
    int         pass_cnt;
    int         fail_cnt;

    assign cmd_sdio = host_oe ? host_bit : 1'bz;
    pullup (cmd_sdio);

    sdio_dev_top i_sdio_dev_top (
        .clk_sdio (clk_sdio),
        .arst_n   (arst_n),
        .cmd_sdio (cmd_sdio)
    );

    bind sdio_cmd sdio_dev_chk i_sdio_dev_chk (
        .clk_sdio   (clk_sdio),
        .arst_n     (arst_n),
        .bit_cnt    (bit_cnt),
        .rx_phase   (rx_phase),
        .req_valid  (req_valid),
        .resp_valid (resp_valid)
    );

    initial begin
        clk_sdio = 1'b0;
        forever #2 clk_sdio = ~clk_sdio;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run did not finish", WATCHDOG_NS);
        $display("test failed");
        $finish;
    end

    // x^7 + x^3 + 1, MSB first
    function automatic logic [6:0] crc7_of(input logic [39:0] bits);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = bits[i] ^ crc[6];
            crc = {crc[5:0], 1'b0} ^ (fb ? 7'h09 : 7'h00);
        end
        return crc;
    endfunction

    task automatic send_frame(input logic [5:0] cmd, input logic [31:0] arg, input logic bad_crc);
        logic [6:0]  crc;
        logic [47:0] frame;
        crc   = crc7_of({2'b01, cmd, arg}) ^ {6'd0, bad_crc};
        frame = {2'b01, cmd, arg, crc, 1'b1};
        repeat (IDLE_CYC) @(posedge clk_sdio);
        for (int i = 47; i >= 0; i--) begin
            #1;
            host_oe  = 1'b1;
            host_bit = frame[i];
            @(posedge clk_sdio);
        end
        #1 host_oe = 1'b0;
    endtask

    task automatic wait_response(output logic got, output logic [47:0] frame);
        got   = 1'b0;
        frame = '1;
        for (int i = 0; i < RESP_WAIT && !got; i++) begin
            @(negedge clk_sdio);
            got = (cmd_sdio === 1'b0);
        end
        if (got) frame[47] = 1'b0;
        for (int i = 46; i >= 0 && got; i--) begin
            @(negedge clk_sdio);
            frame[i] = cmd_sdio;
        end
    endtask

    task automatic run_cmd(input logic [5:0] cmd, input logic [31:0] arg, input logic bad_crc,
                           input logic expect_resp, input logic [31:0] exp_arg);
        logic        got;
        logic [47:0] rsp;
        send_frame(cmd, arg, bad_crc);
        wait_response(got, rsp);
        if (got !== expect_resp) begin
            $display("Response start bit %s for index %0d arg 0x%h",
                     got ? "seen although none was due" : "never came", cmd, arg);
            err_cnt++;
        end else if (got) begin
            if (rsp[46] !== 1'b0) begin
                $display("ERROR cmd_sdio transmission bit expected 0x0 got 0x%h", rsp[46]);
                err_cnt++;
            end
            if (rsp[45:40] !== CMD52) begin
                $display("ERROR resp index expected 0x%h got 0x%h", CMD52, rsp[45:40]);
                err_cnt++;
            end
            if (rsp[39:8] !== exp_arg) begin
                $display("ERROR resp_arg expected 0x%h got 0x%h", exp_arg, rsp[39:8]);
                err_cnt++;
            end
            if (rsp[7:1] !== crc7_of(rsp[47:8])) begin
                $display("ERROR resp crc7 expected 0x%h got 0x%h", crc7_of(rsp[47:8]), rsp[7:1]);
                err_cnt++;
            end
            if (rsp[0] !== 1'b1) begin
                $display("ERROR cmd_sdio end bit expected 0x1 got 0x%h", rsp[0]);
                err_cnt++;
            end
        end
    endtask

    // CMD52 with the expected R5 taken from the bank model
    task automatic cmd52(input logic wr, input logic [2:0] func, input logic raw,
                         input logic [16:0] addr, input logic [7:0] data);
        logic [7:0] flags;
        logic [7:0] rdata;
        flags = {6'd0, int'(func) >= `SDIO_NUM_FUNC, int'(addr) >= `SDIO_REG_DEPTH};
        rdata = 8'h00;
        if (flags == 8'h00) begin
            rdata = shadow[func[FW-1:0]][addr[AW-1:0]];
            if (wr) begin
                shadow[func[FW-1:0]][addr[AW-1:0]] = data;
                if (raw) rdata = data;
            end
        end
        run_cmd(CMD52, {wr, func, raw, 1'b0, addr, 1'b0, data}, 1'b0, 1'b1,
                {16'h0000, flags, rdata});
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("%s: ok", name);
        end else begin
            fail_cnt++;
            $display("%s: %0d errors", name, err_cnt - errs_before);
        end
    endtask

    task automatic test_write_read();
        int          errs;
        logic [31:0] rnd;
        errs = err_cnt;
        for (int f = 0; f < `SDIO_NUM_FUNC; f++) begin
            rnd = $urandom;
            cmd52(1'b1, 3'(f), 1'b1, 17'(rnd % `SDIO_REG_DEPTH), rnd[15:8]);
            cmd52(1'b0, 3'(f), 1'b0, 17'(rnd % `SDIO_REG_DEPTH), 8'h00);
        end
        finish_test("write_read", errs);
    endtask

    task automatic test_write_no_raw();
        int          errs;
        logic [31:0] rnd;
        errs = err_cnt;
        rnd  = $urandom;
        cmd52(1'b1, 3'(rnd % `SDIO_NUM_FUNC), 1'b0, 17'(rnd[11:8]), rnd[23:16]);
        cmd52(1'b1, 3'(rnd % `SDIO_NUM_FUNC), 1'b0, 17'(rnd[11:8]), rnd[31:24]);
        finish_test("write_no_raw", errs);
    endtask

    task automatic test_bad_function();
        int          errs;
        logic [31:0] rnd;
        logic [2:0]  func;
        errs = err_cnt;
        rnd  = $urandom;
        func = 3'(`SDIO_NUM_FUNC + rnd % (8 - `SDIO_NUM_FUNC));
        cmd52(1'b1, func, 1'b1, 17'(rnd[11:8]), rnd[23:16]);
        cmd52(1'b0, 3'(int'(func) - `SDIO_NUM_FUNC), 1'b0, 17'(rnd[11:8]), 8'h00);
        finish_test("bad_function", errs);
    endtask

    task automatic test_bad_address();
        int          errs;
        logic [31:0] rnd;
        logic [16:0] addr;
        errs = err_cnt;
        rnd  = $urandom;
        addr = 17'(`SDIO_REG_DEPTH + rnd % (32'h20000 - `SDIO_REG_DEPTH));
        cmd52(1'b1, 3'(rnd[31:30]), 1'b1, addr, rnd[7:0]);
        cmd52(1'b0, 3'(rnd[31:30]), 1'b0, 17'(addr % `SDIO_REG_DEPTH), 8'h00);
        finish_test("bad_address", errs);
    endtask

    task automatic test_bad_crc();
        int          errs;
        logic [31:0] rnd;
        errs = err_cnt;
        rnd  = $urandom;
        run_cmd(CMD52, {1'b1, 3'(rnd[31:30]), 1'b1, 1'b0, 17'(rnd[11:8]), 1'b0, rnd[7:0]},
                1'b1, 1'b0, 32'h0);
        cmd52(1'b0, 3'(rnd[31:30]), 1'b0, 17'(rnd[11:8]), 8'h00);
        finish_test("bad_crc", errs);
    endtask

    task automatic test_non_cmd52();
        int          errs;
        logic [31:0] rnd;
        logic [5:0]  idx;
        errs = err_cnt;
        rnd  = $urandom;
        idx  = 6'(rnd % 64);
        if (idx == CMD52) idx = 6'd53;
        run_cmd(idx, {1'b1, 3'(rnd[31:30]), 1'b1, 1'b0, 17'(rnd[11:8]), 1'b0, rnd[7:0]},
                1'b0, 1'b0, 32'h0);
        cmd52(1'b0, 3'(rnd[31:30]), 1'b0, 17'(rnd[11:8]), 8'h00);
        finish_test("non_cmd52", errs);
    endtask

    initial begin
        void'($urandom(32'h3add));
        arst_n   = 1'b0;
        host_oe  = 1'b0;
        host_bit = 1'b1;
        err_cnt  = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        foreach (shadow[f, a]) shadow[f][a] = 8'h00;
        repeat (16) @(posedge clk_sdio);
        #1 arst_n = 1'b1;
        test_write_read();
        test_write_no_raw();
        test_bad_function();
        test_bad_address();
        test_bad_crc();
        test_non_cmd52();
        $display("%0d tests ok, %0d tests with errors, %0d assertion failures", pass_cnt,
                 fail_cnt, i_sdio_dev_top.i_sdio_cmd.i_sdio_dev_chk.assert_fails);
        if (fail_cnt == 0 && i_sdio_dev_top.i_sdio_cmd.i_sdio_dev_chk.assert_fails == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/sdio_dev_chk.sv
`timescale 1ns/1ps
`default_nettype none

module sdio_dev_chk (
    input logic       clk_sdio,
    input logic       arst_n,
    input logic [5:0] bit_cnt,
    input logic       rx_phase,
    input logic       req_valid,
    input logic [1:0] resp_valid
);

    localparam logic [5:0] END_BIT = 6'(sdio_proto_pkg::FRM_END_POS);

    int unsigned assert_fails = 0;

    // Driver turns on only once the end bit is in
    a_rx_released: assert property (@(posedge clk_sdio) disable iff (!arst_n)
        $fell(rx_phase) |-> $past(bit_cnt) == END_BIT)
    else begin
        assert_fails++;
        $error("cmd_sdio driven by the device while a request is received");
    end

    a_req_pulse: assert property (@(posedge clk_sdio) disable iff (!arst_n)
        req_valid |=> !req_valid)
    else begin
        assert_fails++;
        $error("req_valid held high for two cycles");
    end

    a_resp_known: assert property (@(posedge clk_sdio) disable iff (!arst_n)
        !$isunknown(resp_valid))
    else begin
        assert_fails++;
        $error("resp_valid is unknown after reset");
    end

endmodule

`default_nettype wire

// File: verilog/sdio_dev_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdio_params.svh"

module sdio_dev_top (
    input logic clk_sdio,
    input logic arst_n,
    inout wire  cmd_sdio
);

    logic [`SDIO_CMD_LEN-1:0]      req_cmd;
    logic [`SDIO_ARG_LEN-1:0]      req_arg;
    logic                          req_valid;
    logic [`SDIO_NUM_FUNC-1:0]     sel;
    logic                          wr;
    logic                          raw;
    sdio_func_pkg::reg_addr_t      addr;
    logic [7:0]                    wdata;
    logic                          err_valid;
    sdio_func_pkg::r5_flags_t      err_flags;
    logic                          err_invalid;
    logic [`SDIO_NUM_FUNC-1:0]     bank_rd_valid;
    logic [`SDIO_NUM_FUNC-1:0][7:0] bank_rdata;
    sdio_proto_pkg::resp_status_e  resp_valid;
    logic [`SDIO_ARG_LEN-1:0]      resp_arg;

    sdio_cmd i_sdio_cmd (
        .clk_sdio   (clk_sdio),
        .arst_n     (arst_n),
        .cmd_sdio   (cmd_sdio),
        .req_cmd    (req_cmd),
        .req_arg    (req_arg),
        .req_valid  (req_valid),
        .resp_arg   (resp_arg),
        .resp_valid (resp_valid)
    );

    sdio_io_dispatch i_sdio_io_dispatch (
        .clk_sdio    (clk_sdio),
        .arst_n      (arst_n),
        .req_cmd     (req_cmd),
        .req_arg     (req_arg),
        .req_valid   (req_valid),
        .sel         (sel),
        .wr          (wr),
        .raw         (raw),
        .addr        (addr),
        .wdata       (wdata),
        .err_valid   (err_valid),
        .err_flags   (err_flags),
        .err_invalid (err_invalid)
    );

    for (genvar g = 0; g < `SDIO_NUM_FUNC; g++) begin : g_func
        sdio_func_regs #(
            .FUNC_IDX (g)
        ) i_sdio_func_regs (
            .clk_sdio (clk_sdio),
            .arst_n   (arst_n),
            .sel      (sel),
            .wr       (wr),
            .raw      (raw),
            .addr     (addr),
            .wdata    (wdata),
            .rd_valid (bank_rd_valid[g]),
            .rdata    (bank_rdata[g])
        );
    end

    sdio_resp_merge i_sdio_resp_merge (
        .clk_sdio    (clk_sdio),
        .arst_n      (arst_n),
        .rd_valid    (bank_rd_valid),
        .rdata       (bank_rdata),
        .err_valid   (err_valid),
        .err_flags   (err_flags),
        .err_invalid (err_invalid),
        .resp_valid  (resp_valid),
        .resp_arg    (resp_arg)
    );

endmodule

`default_nettype wire

// File: verilog/sdio_resp_merge.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdio_params.svh"

module sdio_resp_merge (
    input  logic                           clk_sdio,
    input  logic                           arst_n,
    input  logic [`SDIO_NUM_FUNC-1:0]      rd_valid,
    input  logic [`SDIO_NUM_FUNC-1:0][7:0] rdata,
    input  logic                           err_valid,
    input  sdio_func_pkg::r5_flags_t       err_flags,
    input  logic                           err_invalid,
    output sdio_proto_pkg::resp_status_e   resp_valid,
    output logic [`SDIO_ARG_LEN-1:0]       resp_arg
);

    localparam int PAD = `SDIO_ARG_LEN - 16;

    logic       any_rd;
    logic [7:0] rd_byte;

    assign any_rd = |rd_valid;

    always_comb begin
        rd_byte = 8'h00;
        for (int i = 0; i < `SDIO_NUM_FUNC; i++) begin
            rd_byte = rd_byte | (rdata[i] & {8{rd_valid[i]}});
        end
    end

    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            resp_valid <= sdio_proto_pkg::RESP_BUSY;
        end else if (any_rd) begin
            resp_valid <= sdio_proto_pkg::RESP_READY;
        end else if (err_valid) begin
            resp_valid <= err_invalid ? sdio_proto_pkg::RESP_INVALID
                                      : sdio_proto_pkg::RESP_READY;
        end else begin
            resp_valid <= sdio_proto_pkg::RESP_BUSY;
        end
    end

    // R5 argument is flags then data
    always_ff @(posedge clk_sdio) begin
        if (any_rd) begin
            resp_arg <= {{PAD{1'b0}}, 8'h00, rd_byte};  // No error flags
        end else if (err_valid) begin
            resp_arg <= {{PAD{1'b0}}, err_flags, 8'h00};
        end
    end

endmodule

`default_nettype wire

// File: verilog/sdio_func_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdio_params.svh"

module sdio_func_regs #(
    parameter int FUNC_IDX = 0
) (
    input  logic                      clk_sdio,
    input  logic                      arst_n,
    input  logic [`SDIO_NUM_FUNC-1:0] sel,
    input  logic                      wr,
    input  logic                      raw,
    input  sdio_func_pkg::reg_addr_t  addr,
    input  logic [7:0]                wdata,
    output logic                      rd_valid,
    output logic [7:0]                rdata
);

    localparam int AW = $clog2(`SDIO_REG_DEPTH);

    logic [7:0]    regs [`SDIO_REG_DEPTH];
    logic [AW-1:0] idx;
    logic          hit;

    assign hit = sel[FUNC_IDX];
    assign idx = addr[AW-1:0];  // Range checked upstream

    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `SDIO_REG_DEPTH; i++) begin
                regs[i] <= 8'h00;
            end
            rd_valid <= 1'b0;
            rdata    <= 8'h00;
        end else begin
            rd_valid <= hit;
            if (hit) begin
                if (wr) begin
                    regs[idx] <= wdata;
                    rdata     <= raw ? wdata : regs[idx];  // RAW returns new value
                end else begin
                    rdata <= regs[idx];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/sdio_io_dispatch.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdio_params.svh"

module sdio_io_dispatch (
    input  logic                        clk_sdio,
    input  logic                        arst_n,
    input  logic [`SDIO_CMD_LEN-1:0]    req_cmd,
    input  logic [`SDIO_ARG_LEN-1:0]    req_arg,
    input  logic                        req_valid,
    output logic [`SDIO_NUM_FUNC-1:0]   sel,
    output logic                        wr,
    output logic                        raw,
    output sdio_func_pkg::reg_addr_t    addr,
    output logic [7:0]                  wdata,
    output logic                        err_valid,
    output sdio_func_pkg::r5_flags_t    err_flags,
    output logic                        err_invalid
);

    sdio_func_pkg::func_num_t req_func;
    sdio_func_pkg::reg_addr_t req_addr;
    sdio_func_pkg::r5_flags_t flags;
    logic                     is_cmd52;
    logic                     func_ok;
    logic                     addr_ok;
    logic                     access_ok;

    assign req_func = req_arg[sdio_func_pkg::ARG_FUNC_HI:sdio_func_pkg::ARG_FUNC_LO];
    assign req_addr = req_arg[sdio_func_pkg::ARG_ADDR_HI:sdio_func_pkg::ARG_ADDR_LO];

    assign is_cmd52  = (req_cmd == sdio_proto_pkg::CMD_IO_RW_DIRECT);
    assign func_ok   = int'(req_func) < `SDIO_NUM_FUNC;
    assign addr_ok   = int'(req_addr) < `SDIO_REG_DEPTH;
    assign access_ok = is_cmd52 && func_ok && addr_ok;

    always_comb begin
        flags = '0;
        flags.function_number = !func_ok;
        flags.out_of_range    = !addr_ok;
    end

    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            sel       <= '0;
            err_valid <= 1'b0;
        end else begin
            sel       <= '0;
            err_valid <= req_valid && !access_ok;
            if (req_valid && access_ok) begin
                sel <= {{(`SDIO_NUM_FUNC-1){1'b0}}, 1'b1} << req_func;  // One-hot bank
            end
        end
    end

    always_ff @(posedge clk_sdio) begin
        if (req_valid) begin
            wr          <= req_arg[sdio_func_pkg::ARG_RW_BIT];
            raw         <= req_arg[sdio_func_pkg::ARG_RAW_BIT];
            addr        <= req_addr;
            wdata       <= req_arg[sdio_func_pkg::ARG_DATA_HI:sdio_func_pkg::ARG_DATA_LO];
            err_flags   <= is_cmd52 ? flags : '0;
            err_invalid <= !is_cmd52;
        end
    end

endmodule

`default_nettype wire

// File: sdio_cmd/sdio_cmd.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdio_params.svh"

module sdio_cmd (
    input  logic                         clk_sdio,
    input  logic                         arst_n,
    inout  wire                          cmd_sdio,
    output logic [`SDIO_CMD_LEN-1:0]     req_cmd,
    output logic [`SDIO_ARG_LEN-1:0]     req_arg,
    output logic                         req_valid,
    input  logic [`SDIO_ARG_LEN-1:0]     resp_arg,
    input  sdio_proto_pkg::resp_status_e resp_valid
);

    localparam int TX_LEN = `SDIO_CMD_LEN + `SDIO_ARG_LEN;
    localparam logic [5:0] TX_POS  = 6'(sdio_proto_pkg::FRM_TX_POS);
    localparam logic [5:0] CMD_POS = 6'(sdio_proto_pkg::FRM_CMD_POS);
    localparam logic [5:0] ARG_POS = 6'(sdio_proto_pkg::FRM_ARG_POS);
    localparam logic [5:0] CRC_POS = 6'(sdio_proto_pkg::FRM_CRC_POS);
    localparam logic [5:0] END_POS = 6'(sdio_proto_pkg::FRM_END_POS);
    localparam logic [5:0] TX_CNT  = 6'(TX_LEN);
    localparam logic [5:0] LAST    = 6'(sdio_proto_pkg::FRM_LEN - 1);

    typedef enum logic [1:0] {
        S_REQ_IDLE     = 2'd0,
        S_REQ_PAYLOAD  = 2'd1,
        S_RESP_IDLE    = 2'd2,
        S_RESP_PAYLOAD = 2'd3
    } state_e;

    state_e                   state;
    logic                     rx_phase;
    logic                     crc_clear;
    logic                     crc_enable;
    logic [`SDIO_CRC_LEN-1:0] crc_buf;
    logic [`SDIO_CRC_LEN-1:0] actual_crc;
    logic [5:0]               bit_cnt;
    logic [1:0]               tx_delay;  // One bit of look-ahead for the CRC
    logic [TX_LEN-1:0]        tx_sreg;
    logic                     cmd_prev;

    assign rx_phase  = (state == S_REQ_IDLE) || (state == S_REQ_PAYLOAD);
    assign crc_clear = (state == S_REQ_IDLE) || (state == S_RESP_IDLE);
    assign cmd_sdio  = rx_phase ? 1'bz : tx_delay[1];

    crc7 i_crc7 (
        .clk    (clk_sdio),
        .clear  (crc_clear),
        .enable (crc_enable),
        .in     (rx_phase ? cmd_sdio : tx_delay[0]),
        .crc    (actual_crc)
    );

    always_ff @(posedge clk_sdio or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_REQ_IDLE;
            req_valid  <= 1'b0;
            req_cmd    <= '0;
            req_arg    <= '0;
            crc_buf    <= '0;
            crc_enable <= 1'b0;
            bit_cnt    <= '0;
            tx_delay   <= 2'b11;
            tx_sreg    <= '0;
            cmd_prev   <= 1'b1;
        end else begin
            req_valid <= 1'b0;
            case (state)
                S_REQ_IDLE: begin
                    cmd_prev <= cmd_sdio;
                    if (cmd_prev && !cmd_sdio) begin  // Start bit
                        crc_enable <= 1'b1;
                        bit_cnt    <= '0;
                        state      <= S_REQ_PAYLOAD;
                    end
                end

                S_REQ_PAYLOAD: begin
                    bit_cnt <= bit_cnt + 6'd1;
                    if (bit_cnt >= CMD_POS && bit_cnt < ARG_POS) begin
                        req_cmd <= {req_cmd[`SDIO_CMD_LEN-2:0], cmd_sdio};
                    end else if (bit_cnt >= ARG_POS && bit_cnt < CRC_POS) begin
                        req_arg <= {req_arg[`SDIO_ARG_LEN-2:0], cmd_sdio};
                    end else if (bit_cnt >= CRC_POS && bit_cnt < END_POS) begin
                        crc_buf <= {crc_buf[`SDIO_CRC_LEN-2:0], cmd_sdio};
                    end

                    if (bit_cnt == TX_POS && !cmd_sdio) begin
                        state <= S_REQ_IDLE;  // Not host to card
                    end
                    if (bit_cnt == CRC_POS - 6'd1) begin
                        crc_enable <= 1'b0;
                    end
                    if (bit_cnt == END_POS) begin
                        if (cmd_sdio && actual_crc == crc_buf) begin
                            tx_delay  <= 2'b11;
                            req_valid <= 1'b1;
                            state     <= S_RESP_IDLE;
                        end else begin
                            state <= S_REQ_IDLE;
                        end
                    end
                end

                S_RESP_IDLE: begin
                    if (resp_valid == sdio_proto_pkg::RESP_READY) begin
                        bit_cnt    <= '0;
                        tx_delay   <= 2'b00;  // Start and transmission bits
                        tx_sreg    <= {req_cmd, resp_arg};
                        crc_enable <= 1'b1;
                        state      <= S_RESP_PAYLOAD;
                    end else if (resp_valid == sdio_proto_pkg::RESP_INVALID) begin
                        state <= S_REQ_IDLE;
                    end
                end

                S_RESP_PAYLOAD: begin
                    bit_cnt <= bit_cnt + 6'd1;
                    if (bit_cnt < TX_CNT) begin
                        tx_delay <= {tx_delay[0], tx_sreg[TX_LEN-1]};
                        tx_sreg  <= tx_sreg << 1;
                    end else if (bit_cnt == TX_CNT) begin
                        tx_delay[1] <= tx_delay[0];
                        crc_enable  <= 1'b0;
                    end else if (bit_cnt == CRC_POS) begin
                        // Remaining CRC bits followed by the end bit
                        tx_delay[1] <= actual_crc[6];
                        tx_sreg     <= {actual_crc[5:0], 1'b1, {(TX_LEN-7){1'b0}}};
                    end else if (bit_cnt < LAST) begin
                        tx_delay[1] <= tx_sreg[TX_LEN-1];
                        tx_sreg     <= tx_sreg << 1;
                    end else begin
                        state <= S_REQ_IDLE;
                    end
                end

                default: state <= S_REQ_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: sdio_cmd/crc7.sv
`timescale 1ns/1ps
`default_nettype none
`include "sdio_params.svh"

module crc7 (
    input  logic                     clk,
    input  logic                     clear,
    input  logic                     enable,
    input  logic                     in,
    output logic [`SDIO_CRC_LEN-1:0] crc
);

    logic fb;

    assign fb = in ^ crc[6];

    // x^7 + x^3 + 1
    always_ff @(posedge clk) begin
        if (clear) begin
            crc <= '0;
        end else if (enable) begin
            crc <= {crc[5:3], crc[2] ^ fb, crc[1:0], fb};
        end
    end

endmodule

`default_nettype wire

// File: common/sdio_func_pkg.sv
`default_nettype none

package sdio_func_pkg;

    typedef logic [2:0]  func_num_t;
    typedef logic [16:0] reg_addr_t;

    typedef struct packed {
        logic       com_crc_error;
        logic       illegal_command;
        logic [1:0] io_current_state;
        logic       error;
        logic       rfu;
        logic       function_number;
        logic       out_of_range;
    } r5_flags_t;

    // CMD52 argument layout
    localparam int ARG_RW_BIT  = 31;
    localparam int ARG_FUNC_HI = 30;
    localparam int ARG_FUNC_LO = 28;
    localparam int ARG_RAW_BIT = 27;
    localparam int ARG_ADDR_HI = 25;
    localparam int ARG_ADDR_LO = 9;
    localparam int ARG_DATA_HI = 7;
    localparam int ARG_DATA_LO = 0;

endpackage

`default_nettype wire

// File: common/sdio_proto_pkg.sv
`default_nettype none
`include "sdio_params.svh"

package sdio_proto_pkg;

    localparam logic [`SDIO_CMD_LEN-1:0] CMD_IO_RW_DIRECT   = 6'd52;
    localparam logic [`SDIO_CMD_LEN-1:0] CMD_IO_RW_EXTENDED = 6'd53;

    typedef enum logic [1:0] {
        RESP_READY   = 2'd0,
        RESP_BUSY    = 2'd1,
        RESP_INVALID = 2'd2
    } resp_status_e;

    // Bit positions counted from the transmission bit
    localparam int FRM_TX_POS  = 0;
    localparam int FRM_CMD_POS = FRM_TX_POS + 1;
    localparam int FRM_ARG_POS = FRM_CMD_POS + `SDIO_CMD_LEN;
    localparam int FRM_CRC_POS = FRM_ARG_POS + `SDIO_ARG_LEN;
    localparam int FRM_END_POS = FRM_CRC_POS + `SDIO_CRC_LEN;
    localparam int FRM_LEN     = FRM_END_POS + 2;  // Start bit included

endpackage

`default_nettype wire

// File: common/sdio_params.svh
`ifndef SDIO_PARAMS_SVH
`define SDIO_PARAMS_SVH

// Command frame fields
`define SDIO_CMD_LEN 6
`define SDIO_ARG_LEN 32
`define SDIO_CRC_LEN 7

// Function register banks
`define SDIO_NUM_FUNC 4
`define SDIO_REG_DEPTH 16

`endif
